// File: Makefile
VERILATOR ?= verilator
TOP       ?= shift_unit_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || (echo "simulation did not complete"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+include
logic/shift_pkg.sv
logic/shift_req_if.sv
logic/shift_decoder.sv
logic/shift_queue.sv
logic/full_barrel_shifter.sv
logic/shift_writeback.sv
logic/shift_unit_top.sv
bench/shift_unit_props.sv
bench/shift_unit_tb.sv

// File: bench/shift_unit_props.sv
`timescale 1ns/1ps

module shift_unit_props (
    input logic clk,
    input logic rst,
    input logic instr_valid,
    input logic ready,
    input logic illegal,
    input logic overflow,
    input logic result_valid,
    input logic dec_valid,
    input logic q_empty
);
    import shift_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reset state and strobe timing.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_state: assert property (@(posedge clk)
        rst |=> (ready && !illegal && !overflow && !result_valid))
        else $error("outputs not idle after reset");

    a_one_outcome: assert property (@(posedge clk) disable iff (rst)
        instr_valid |=> (illegal != dec_valid))
        else $error("strobe gave neither or both of request and illegal");

    a_illegal_no_result: assert property (@(posedge clk) disable iff (rst)
        (illegal && q_empty) |=> ##1 !result_valid)
        else $error("illegal word produced a result");

    a_empty_latency: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && q_empty) |=> ##1 result_valid)
        else $error("result did not follow the strobe by two cycles");

    a_accept_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (instr_valid && ready) |=> !overflow)
        else $error("request accepted while ready was dropped");

endmodule

bind shift_unit_top shift_unit_props u_props (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .ready       (ready),
    .illegal     (illegal),
    .overflow    (overflow),
    .result_valid(result_valid),
    .dec_valid   (dec_req.valid),
    .q_empty     (u_queue.empty)
);

// File: bench/shift_unit_tb.sv
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_unit_tb;
    import shift_pkg::*;

    localparam int XW         = `SHIFT_XLEN;
    localparam int SW         = $clog2(XW);
    localparam int NUM_RANDOM = 300;
    localparam int NUM_TOTAL  = NUM_RANDOM + 40;

    logic clk, rst, instr_valid, ready, illegal, overflow, result_valid;
    logic [31:0] instr;
    logic [XW-1:0] rs1_data, rs2_data, result_data;
    logic [4:0] result_rd;

    logic [XW-1:0] exp_q [$]; // expected results in issue order.
    logic [4:0] rd_q [$];
    logic cur_legal, st_valid, st_legal, st_ready;
    logic [4:0] cur_rd, st_rd;
    logic [XW-1:0] cur_exp, st_exp;
    int value_errors = 0;
    int other_errors = 0;
    int drops = 0;

    shift_unit_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [XW-1:0] rand_word();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[XW-1:0];
    endfunction

    task automatic drive(input logic [31:0] w, input logic [XW-1:0] a, input logic [XW-1:0] b,
                         input logic legal, input logic [4:0] rd, input logic [XW-1:0] exp);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        rs1_data    <= a;
        rs2_data    <= b;
        cur_legal = legal;
        cur_rd    = rd;
        cur_exp   = exp;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    // kind 0..2 is the register form of SLL, SRL, SRA; 3..5 the immediate form.
    task automatic send_shift(input int kind, input logic [XW-1:0] a, input logic [SW-1:0] sh,
                              input logic [4:0] rd);
        logic [XW-1:0] b;
        logic [XW-1:0] exp;
        logic [31:0] w;
        logic [2:0] f3;
        logic arith;
        arith = (kind % 3 == 2);
        f3 = (kind % 3 == 0) ? 3'b001 : 3'b101;
        b = rand_word();
        b[SW-1:0] = sh; // upper rs2 bits must be ignored.
        if (kind < 3) w = {1'b0, arith, 5'b0, 5'($urandom()), 5'($urandom()), f3, rd, OPC_OP};
        else w = {1'b0, arith, {(10-SW){1'b0}}, sh, 5'($urandom()), f3, rd, OPC_OP_IMM};
        case (kind % 3)
            0: exp = a << sh;
            1: exp = a >> sh;
            default: exp = XW'($signed(a) >>> sh);
        endcase
        drive(w, a, b, 1'b1, rd, exp);
    endtask

    task automatic send_illegal(input logic [31:0] w);
        drive(w, rand_word(), rand_word(), 1'b0, 5'd0, '0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scoreboard, sampled on the falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!rst && st_valid) begin
            if (st_legal) begin
                assert (!illegal) else begin
                    $display("FAIL illegal got %h expected %h", illegal, 1'b0);
                    value_errors++;
                end
                if (!st_ready) begin
                    drops++; // refused at a full queue.
                    assert (overflow) else begin
                        $display("FAIL overflow got %h expected %h", overflow, 1'b1);
                        value_errors++;
                    end
                end else begin
                    exp_q.push_back(st_exp);
                    rd_q.push_back(st_rd);
                end
            end else begin
                assert (illegal) else begin
                    $display("FAIL illegal got %h expected %h", illegal, 1'b1);
                    value_errors++;
                end
            end
        end
        if (!rst && result_valid) begin
            if (exp_q.size() == 0) begin
                $display("result arrived with no instruction waiting for it");
                other_errors++;
            end else begin
                assert (result_data == exp_q[0]) else begin
                    $display("FAIL result_data got %h expected %h", result_data, exp_q[0]);
                    value_errors++;
                end
                assert (result_rd == rd_q[0]) else begin
                    $display("FAIL result_rd got %h expected %h", result_rd, rd_q[0]);
                    value_errors++;
                end
                void'(exp_q.pop_front());
                void'(rd_q.pop_front());
            end
        end
        st_valid = instr_valid && !rst;
        st_ready = ready;
        st_legal = cur_legal;
        st_rd    = cur_rd;
        st_exp   = cur_exp;
    end

    initial begin
        repeat (NUM_TOTAL * 8 + 200) @(posedge clk);
        $display("timeout, the run did not finish in the expected time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int spins;
        void'($urandom(32'h2f68));
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        rs1_data = '0;
        rs2_data = '0;
        cur_legal = 1'b0;
        cur_rd = '0;
        cur_exp = '0;
        st_valid = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        idle(2);
        for (int k = 0; k < 6; k++) begin
            send_shift(k, rand_word(), '0, 5'(k + 1));
            send_shift(k, rand_word(), SW'(XW - 1), 5'(k + 9));
        end
        idle(2);
        send_shift(2, {1'b1, rand_word()} >> 1 | {1'b1, {(XW-1){1'b0}}}, SW'(5), 5'd20);
        send_shift(5, rand_word() >> 1, SW'(7), 5'd21); // positive, acts as SRL.
        send_shift(5, {1'b1, {(XW-1){1'b0}}} | rand_word(), SW'(XW - 1), 5'd22);
        send_shift(2, rand_word() >> 1, SW'(XW - 1), 5'd23);
        send_illegal({7'b0000001, 5'd3, 5'd4, 3'b001, 5'd5, OPC_OP});      // bad funct7
        send_illegal({7'b0100000, 5'd3, 5'd4, 3'b001, 5'd5, OPC_OP_IMM});  // no SLAI
        send_illegal({2'b00, 1'b1, 9'd3, 5'd4, 3'b101, 5'd5, OPC_OP_IMM}); // upper shamt
        send_illegal({7'b0, 5'd3, 5'd4, 3'b000, 5'd5, OPC_OP});            // ADD
        send_illegal({20'h12345, 5'd5, 7'b0110111});                       // LUI
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if ($urandom() % 8 == 0) send_illegal($urandom() | 32'h8000_0000); // never a shift.
            else send_shift($urandom() % 6, rand_word(), SW'($urandom()), 5'($urandom()));
            if ($urandom() % 4 == 0) idle($urandom() % 3 + 1);
        end
        idle(1);
        spins = 0;
        while ((exp_q.size() != 0 || st_valid) && spins < 64) begin
            @(posedge clk);
            spins++;
        end
        idle(4);
        if (exp_q.size() != 0) begin
            $display("results still missing after the queue drained");
            other_errors++;
        end
        $display("value errors %0d, other errors %0d, dropped %0d",
                 value_errors, other_errors, drops);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: include/shift_defs.svh
`ifndef SHIFT_DEFS_SVH
`define SHIFT_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sizes shared by the shift unit.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SHIFT_XLEN   32 // data width, 32 or 64.

`define SHIFT_QDEPTH 4  // request queue entries, must be a power of two.

`endif

// File: logic/full_barrel_shifter.sv
`timescale 1ns/1ps
`include "shift_defs.svh"

module full_barrel_shifter #(
    parameter int XLEN = `SHIFT_XLEN
) (
    input  logic [XLEN-1:0]         in_data,
    input  logic [$clog2(XLEN)-1:0] shamt,
    input  logic                    left_or_right_shift,    // 1 shifts right.
    input  logic                    arithmetic_right_shift, // 1 fills with the sign.
    output logic [XLEN-1:0]         out_data
);

    localparam int SW = $clog2(XLEN);

    logic [XLEN-1:0] stage [SW+1]; // stage 0 is the input, stage SW the result.
    logic            fill;

    assign stage[0]  = in_data;
    assign out_data  = stage[SW];
    assign fill      = arithmetic_right_shift && in_data[XLEN-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One column of 2-to-1 muxes per shamt bit.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < SW; i++) begin : g_stage
        localparam int STEP = 1 << i;

        for (genvar j = 0; j < XLEN; j++) begin : g_bit
            logic lo_bit; // source bit for a left shift.
            logic hi_bit; // source bit for a right shift.
            logic moved;

            if (j >= STEP) begin : g_lo
                assign lo_bit = stage[i][j-STEP];
            end else begin : g_lo_zero
                assign lo_bit = 1'b0;
            end

            if (j + STEP < XLEN) begin : g_hi
                assign hi_bit = stage[i][j+STEP];
            end else begin : g_hi_fill
                assign hi_bit = fill; // top bits of a right shift.
            end

            assign moved          = left_or_right_shift ? hi_bit : lo_bit;
            assign stage[i+1][j]  = shamt[i] ? moved : stage[i][j];
        end
    end

endmodule

// File: logic/shift_decoder.sv
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [31:0]            instr,
    input  logic [`SHIFT_XLEN-1:0] rs1_data,
    input  logic [`SHIFT_XLEN-1:0] rs2_data,
    shift_req_if.src               req,
    output logic                   illegal
);
    import shift_pkg::*;

    localparam int SW = $clog2(`SHIFT_XLEN);

    opcode_e       opcode;
    logic          is_reg;
    logic          is_imm;
    logic          upper_zero;
    logic          dec_ok;
    shift_op_e     dec_op;
    logic [SW-1:0] dec_shamt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Classify the word.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        opcode     = opcode_e'(instr[6:0]);
        is_reg     = (opcode == OPC_OP);
        is_imm     = (opcode == OPC_OP_IMM);
        upper_zero = is_reg ? (instr[29:25] == '0) : (instr[29:20+SW] == '0); // bit 30 aside.
        dec_shamt  = is_reg ? rs2_data[SW-1:0] : instr[20 +: SW];
        dec_op     = SHIFT_SLL;
        dec_ok     = 1'b0;
        if ((is_reg || is_imm) && !instr[31] && upper_zero) begin
            case (instr[14:12])
                3'b001: begin
                    dec_op = SHIFT_SLL;
                    dec_ok = !instr[30]; // there is no arithmetic left shift.
                end
                3'b101: begin
                    dec_op = instr[30] ? SHIFT_SRA : SHIFT_SRL;
                    dec_ok = 1'b1;
                end
                default: dec_ok = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            req.valid <= instr_valid && dec_ok;
            illegal   <= instr_valid && !dec_ok; // dropped here, never queued.
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            req.op    <= dec_op;
            req.data  <= rs1_data;
            req.shamt <= dec_shamt;
            req.rd    <= instr[11:7];
        end
    end

endmodule

// File: logic/shift_pkg.sv
`include "shift_defs.svh"

package shift_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded shift operation.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        SHIFT_SLL = 2'b00, // logical left.
        SHIFT_SRL = 2'b01, // logical right.
        SHIFT_SRA = 2'b10  // arithmetic right, sign fill.
    } shift_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Major opcodes that can carry a shift.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // register-register form.
        OPC_OP_IMM = 7'b0010011  // register-immediate form.
    } opcode_e;

endpackage

// File: logic/shift_queue.sv
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_queue (
    input  logic     clk,
    input  logic     rst,
    shift_req_if.dst enq,
    shift_req_if.src head,
    input  logic     pop,
    output logic     ready,
    output logic     overflow
);
    import shift_pkg::*;

    localparam int DEPTH = `SHIFT_QDEPTH;
    localparam int AW    = $clog2(DEPTH);
    localparam int SW    = $clog2(`SHIFT_XLEN);

    shift_op_e              op_mem    [DEPTH];
    logic [`SHIFT_XLEN-1:0] data_mem  [DEPTH];
    logic [SW-1:0]          shamt_mem [DEPTH];
    logic [4:0]             rd_mem    [DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          empty;
    logic          do_push;
    logic          do_pop;

    assign empty    = (count == '0);
    assign full     = (count == (AW+1)'(DEPTH));
    assign do_pop   = pop && !empty;
    assign do_push  = enq.valid && (!full || do_pop); // a pop frees the slot first.
    assign ready    = !full;
    assign overflow = enq.valid && full && !do_pop;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1; // pointers wrap on their own.
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            op_mem[wr_ptr]    <= enq.op;
            data_mem[wr_ptr]  <= enq.data;
            shamt_mem[wr_ptr] <= enq.shamt;
            rd_mem[wr_ptr]    <= enq.rd;
        end
    end

    assign head.valid = !empty; // the oldest entry is always on show.
    assign head.op    = op_mem[rd_ptr];
    assign head.data  = data_mem[rd_ptr];
    assign head.shamt = shamt_mem[rd_ptr];
    assign head.rd    = rd_mem[rd_ptr];

endmodule

// File: logic/shift_req_if.sv
`timescale 1ns/1ps
`include "shift_defs.svh"

interface shift_req_if;
    import shift_pkg::*;

    logic                             valid; // one-cycle strobe or not-empty level.
    shift_op_e                        op;
    logic [`SHIFT_XLEN-1:0]           data;  // operand to be shifted.
    logic [$clog2(`SHIFT_XLEN)-1:0]   shamt;
    logic [4:0]                       rd;

    modport src (
        output valid,
        output op,
        output data,
        output shamt,
        output rd
    );

    modport dst (
        input valid,
        input op,
        input data,
        input shamt,
        input rd
    );

endinterface

// File: logic/shift_unit_top.sv
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_unit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  logic [31:0]            instr,
    input  logic [`SHIFT_XLEN-1:0] rs1_data,
    input  logic [`SHIFT_XLEN-1:0] rs2_data,
    output logic                   ready,
    output logic                   illegal,
    output logic                   overflow,
    output logic                   result_valid,
    output logic [`SHIFT_XLEN-1:0] result_data,
    output logic [4:0]             result_rd
);

    shift_req_if dec_req ();  // decoder to queue.
    shift_req_if head_req (); // queue head to writeback.

    logic pop;

    shift_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .instr_valid(instr_valid),
        .instr      (instr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .req        (dec_req.src),
        .illegal    (illegal)
    );

    shift_queue u_queue (
        .clk     (clk),
        .rst     (rst),
        .enq     (dec_req.dst),
        .head    (head_req.src),
        .pop     (pop),
        .ready   (ready),
        .overflow(overflow)
    );

    shift_writeback u_writeback (
        .clk         (clk),
        .rst         (rst),
        .head        (head_req.dst),
        .pop         (pop),
        .result_valid(result_valid),
        .result_data (result_data),
        .result_rd   (result_rd)
    );

endmodule

// File: logic/shift_writeback.sv
`timescale 1ns/1ps
`include "shift_defs.svh"

module shift_writeback (
    input  logic                   clk,
    input  logic                   rst,
    shift_req_if.dst               head,
    output logic                   pop,
    output logic                   result_valid,
    output logic [`SHIFT_XLEN-1:0] result_data,
    output logic [4:0]             result_rd
);
    import shift_pkg::*;

    logic [`SHIFT_XLEN-1:0] shifted;
    logic                   dir_right;
    logic                   arith;

    assign pop       = head.valid; // one request per cycle, no stall.
    assign dir_right = (head.op != SHIFT_SLL);
    assign arith     = (head.op == SHIFT_SRA);

    full_barrel_shifter #(
        .XLEN(`SHIFT_XLEN)
    ) u_shifter (
        .in_data               (head.data),
        .shamt                 (head.shamt),
        .left_or_right_shift   (dir_right),
        .arithmetic_right_shift(arith),
        .out_data              (shifted)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Result register.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= head.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (head.valid) begin
            result_data <= shifted;
            result_rd   <= head.rd; // travels with its data.
        end
    end

endmodule
